// File: sim/uart_patterns.txt
# columns: test name, baud divisor (decimal), data byte (hex), injected error flag
# flag 1 sends the byte with its stop bit held low and expects a framing error
div3_a5 3 a5 0
div3_00 3 00 0
div3_ff 3 ff 0
div3_3c 3 3c 0
div7_5a 7 5a 0
div7_01 7 01 0
div7_80 7 80 0
div7_err_c3 7 c3 1
div7_e7 7 e7 0
div15_96 15 96 0
div15_7e 15 7e 0
div15_fe 15 fe 0
div15_err_00 15 00 1
div15_69 15 69 0
div4_d2 4 d2 0
div5_2b 5 2b 0
div3_after_err 3 44 0
div15_last 15 11 0

// File: tb.f
verilog/uart_frame_pkg.sv
verilog/uart_cfg_pkg.sv
verilog/uart_tx_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_core.sv
sim/uart_core_chk.sv
sim/uart_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the uart core testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module uart_core_tb -o uart_core_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/uart_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

// File: sim/uart_core_tb.sv
// testbench for the uart core running loopback, timing, FIFO and framing cases from a vector file
`timescale 1ns/1ps
`default_nettype none

module uart_core_tb;

    localparam int MAX_VEC = 32;

    logic        clk_i = 1'b0;
    logic        rst_i = 1'b1;
    logic [15:0] baud_div_i = 16'd3;
    logic        wr_en_i = 1'b0;
    logic [7:0]  wr_data_i = 8'h00;
    logic        rx_i;
    logic        bang_en = 1'b0; // testbench takes over the receive line
    logic        bang_val = 1'b1;
    wire         fifo_full_o;
    wire         tx_o;
    wire         tx_busy_o;
    wire         rx_valid_o;
    wire         rx_frame_err_o;
    wire  [7:0]  rx_data_o;

    string       vec_name [MAX_VEC];
    int          vec_div  [MAX_VEC];
    int          vec_byte [MAX_VEC];
    int          vec_err  [MAX_VEC];
    int          vec_count = 0;
    logic        vectors_loaded = 1'b0;
    longint      watchdog_ns = 0;
    logic [7:0]  expect_q [$];
    string       cur_name = "reset";
    int          error_count = 0;
    int          check_count = 0;
    int          rx_count = 0;
    int          err_count = 0;
    logic [31:0] rng_state = 32'h3e2c_9de9;

    assign rx_i = bang_en ? bang_val : tx_o;

    always #20 clk_i = ~clk_i;

    uart_core uart_core_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .baud_div_i     (baud_div_i),
        .wr_en_i        (wr_en_i),
        .wr_data_i      (wr_data_i),
        .fifo_full_o    (fifo_full_o),
        .tx_o           (tx_o),
        .tx_busy_o      (tx_busy_o),
        .rx_i           (rx_i),
        .rx_data_o      (rx_data_o),
        .rx_valid_o     (rx_valid_o),
        .rx_frame_err_o (rx_frame_err_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_equal(input string test, input string what, input int exp, input int act);
        check_count++;
        assert (exp == act) else begin
            $display("** Error %0s: %0s expected %0h actual %0h", test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic write_byte(input logic [7:0] b);
        wr_en_i   = 1'b1;
        wr_data_i = b;
        next_cycle();
        wr_en_i   = 1'b0;
    endtask

    // bit k of the frame on tx_o follows from k / (div + 1) over start, eight data bits and stop
    task automatic check_frame(input string test, input int div, input logic [7:0] b);
        int   bitlen;
        int   wait_cycles;
        int   bit_no;
        logic exp_bit;
        bitlen = div + 1;
        wait_cycles = 0;
        @(negedge clk_i);
        while (tx_o && wait_cycles < 4 * bitlen + 20) begin
            @(negedge clk_i);
            wait_cycles++;
        end
        if (tx_o) begin
            $display("%0s: no start bit appeared on tx_o", test);
            error_count++;
        end else begin
            for (int k = 0; k < 10 * bitlen; k++) begin
                bit_no  = k / bitlen;
                exp_bit = (bit_no == 0) ? 1'b0 : (bit_no == 9) ? 1'b1 : b[bit_no-1];
                check_equal(test, $sformatf("tx_o at cycle %0d", k), int'(exp_bit), int'(tx_o));
                check_equal(test, $sformatf("tx_busy_o at cycle %0d", k),
                            (k == 10 * bitlen - 1) ? 0 : 1, int'(tx_busy_o));
                if (k != 10 * bitlen - 1) begin
                    @(negedge clk_i);
                end
            end
        end
    endtask

    task automatic wait_count(input string test, input bit want_err, input int target,
                              input int limit);
        int n;
        n = 0;
        while ((want_err ? err_count : rx_count) < target && n < limit) begin
            next_cycle();
            n++;
        end
        if ((want_err ? err_count : rx_count) < target) begin
            if (want_err) begin
                $display("%0s: receiver gave no framing error within %0d cycles", test, limit);
            end else begin
                $display("%0s: receiver gave no byte within %0d cycles", test, limit);
            end
            error_count++;
        end
    endtask

    task automatic bang_frame(input int div, input logic [7:0] b);
        logic [9:0] bits;
        bits = {1'b0, b, 1'b0}; // stop bit forced low
        bang_en = 1'b1;
        for (int i = 0; i < 10; i++) begin
            bang_val = bits[i];
            repeat (div + 1) next_cycle();
        end
        bang_val = 1'b1;
        repeat (3 * (div + 1)) next_cycle();
        bang_en = 1'b0;
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        string nm;
        int    d;
        int    b;
        int    e;
        fd = $fopen("sim/uart_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/uart_patterns.txt");
            error_count++;
        end else begin
            while (!$feof(fd) && vec_count < MAX_VEC) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#" &&
                    $sscanf(line, "%s %d %h %d", nm, d, b, e) == 4) begin
                    vec_name[vec_count] = nm;
                    vec_div[vec_count]  = d;
                    vec_byte[vec_count] = b;
                    vec_err[vec_count]  = e;
                    watchdog_ns += longint'(12 * (d + 1) * 40);
                    vec_count++;
                end
            end
            $fclose(fd);
        end
        watchdog_ns += 14 * 10 * 16 * 40 + 20000; // burst case and settling
        vectors_loaded = 1'b1;
    endtask

    // receive side scoreboard
    always @(negedge clk_i) begin
        if (!rst_i && rx_valid_o) begin
            if (expect_q.size() == 0) begin
                $display("%0s: rx_valid_o pulsed with no byte outstanding", cur_name);
                error_count++;
            end else begin
                check_equal(cur_name, "rx_data_o", int'(expect_q.pop_front()), int'(rx_data_o));
            end
            rx_count++;
        end
        if (!rst_i && rx_frame_err_o) begin
            err_count++;
        end
    end

    initial begin
        wait (vectors_loaded);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int n_burst;
        int accepted;
        int target;
        int rx_before;
        int exp_errors;
        bit full_seen;
        load_vectors();
        exp_errors = 0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        next_cycle();
        check_equal("reset", "tx_o", 1, int'(tx_o));
        check_equal("reset", "tx_busy_o", 0, int'(tx_busy_o));
        check_equal("reset", "fifo_full_o", 0, int'(fifo_full_o));
        check_equal("reset", "rx_valid_o", 0, int'(rx_valid_o));
        check_equal("reset", "rx_frame_err_o", 0, int'(rx_frame_err_o));

        for (int i = 0; i < vec_count; i++) begin
            cur_name   = vec_name[i];
            baud_div_i = 16'(vec_div[i]);
            repeat (2) next_cycle();
            if (vec_err[i] != 0) begin
                exp_errors++;
                target    = err_count + 1;
                rx_before = rx_count;
                bang_frame(vec_div[i], 8'(vec_byte[i]));
                wait_count(cur_name, 1'b1, target, 4 * (vec_div[i] + 1));
                check_equal(cur_name, "framing errors", target, err_count);
                check_equal(cur_name, "bytes during bad frame", rx_before, rx_count);
            end else begin
                target = rx_count + 1;
                expect_q.push_back(8'(vec_byte[i]));
                fork
                    check_frame(cur_name, vec_div[i], 8'(vec_byte[i]));
                    write_byte(8'(vec_byte[i]));
                join
                wait_count(cur_name, 1'b0, target, 4 * (vec_div[i] + 1));
                check_equal(cur_name, "bytes received", target, rx_count);
            end
            repeat (4) next_cycle();
        end

        // a burst while a frame is on the line fills 8 FIFO entries plus 1 in the transmitter
        cur_name   = "fifo_burst";
        baud_div_i = 16'd7;
        rng_state  = xorshift32(rng_state);
        n_burst    = 9 + int'(rng_state % 4);
        target     = rx_count;
        rng_state  = xorshift32(rng_state);
        expect_q.push_back(rng_state[7:0]);
        write_byte(rng_state[7:0]);
        accepted   = 1;
        full_seen  = 1'b0;
        while (!tx_busy_o) next_cycle();
        for (int i = 1; i < n_burst; i++) begin
            if (accepted >= 9 && fifo_full_o) full_seen = 1'b1;
            rng_state = xorshift32(rng_state);
            if (!fifo_full_o) begin
                expect_q.push_back(rng_state[7:0]);
                accepted++;
            end
            write_byte(rng_state[7:0]);
        end
        if (fifo_full_o) full_seen = 1'b1;
        check_equal(cur_name, "accepted writes", 9, accepted);
        check_equal(cur_name, "fifo_full_o after 9 writes", 1, int'(full_seen));
        wait_count(cur_name, 1'b0, target + accepted, accepted * 10 * 8 + 200);
        check_equal(cur_name, "bytes received", target + accepted, rx_count);
        check_equal(cur_name, "framing errors seen", exp_errors, err_count);

        $display("checks %0d, errors %0d, bytes received %0d, framing errors %0d",
                 check_count, error_count, rx_count, err_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/uart_core_chk.sv
// concurrent checks on the uart transmit line, receiver strobes and FIFO write side
`timescale 1ns/1ps
`default_nettype none

module uart_core_chk (
    input wire clk_i,
    input wire rst_i,
    input wire tx_o,
    input wire tx_busy_o,
    input wire rx_valid_o,
    input wire rx_frame_err_o,
    input wire wr_en_i,
    input wire fifo_full_o,
    input wire tx_start_i
);

    // an idle transmitter holds the line at the stop level
    idle_line_high: assert property (@(posedge clk_i) disable iff (rst_i)
        !tx_busy_o |-> tx_o)
        else $error("tx_o low while the transmitter is idle");

    // a frame ends either good or with a framing error, never both
    rx_strobes_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(rx_valid_o && rx_frame_err_o))
        else $error("rx_valid_o and rx_frame_err_o high in the same cycle");

    // a write into a full FIFO with no pop leaves it full, so nothing was stored
    full_write_dropped: assert property (@(posedge clk_i) disable iff (rst_i)
        (wr_en_i && fifo_full_o && !tx_start_i) |=> fifo_full_o)
        else $error("write into a full FIFO changed its state");

endmodule

bind uart_core uart_core_chk uart_core_chk_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .tx_o           (tx_o),
    .tx_busy_o      (tx_busy_o),
    .rx_valid_o     (rx_valid_o),
    .rx_frame_err_o (rx_frame_err_o),
    .wr_en_i        (wr_en_i),
    .fifo_full_o    (fifo_full_o),
    .tx_start_i     (tx_start)
);

`default_nettype wire

// File: verilog/uart_core.sv
// uart top level joining the transmit FIFO, the transmitter and the receiver
`timescale 1ns/1ps
`default_nettype none

module uart_core (
    input  wire                                  clk_i,
    input  wire                                  rst_i,
    input  wire  [uart_cfg_pkg::BAUD_W-1:0]      baud_div_i,
    input  wire                                  wr_en_i,
    input  wire  [uart_frame_pkg::DATA_BITS-1:0] wr_data_i,
    output logic                                 fifo_full_o,
    output logic                                 tx_o,
    output logic                                 tx_busy_o,
    input  wire                                  rx_i,
    output logic [uart_frame_pkg::DATA_BITS-1:0] rx_data_o,
    output logic                                 rx_valid_o,
    output logic                                 rx_frame_err_o
);

    logic                                 fifo_empty;
    logic [uart_frame_pkg::DATA_BITS-1:0] fifo_data;
    logic                                 tx_ready;
    logic                                 tx_start;

    // the byte handed to the transmitter leaves the FIFO in the same cycle
    assign tx_start  = tx_ready && !fifo_empty;
    assign tx_busy_o = !tx_ready;

    uart_tx_fifo uart_tx_fifo_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (wr_en_i),
        .push_data_i (wr_data_i),
        .pop_i       (tx_start),
        .pop_data_o  (fifo_data),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full_o)
    );

    uart_tx uart_tx_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .baud_div_i (baud_div_i),
        .start_i    (tx_start),
        .data_i     (fifo_data),
        .ready_o    (tx_ready),
        .tx_o       (tx_o)
    );

    uart_rx uart_rx_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .baud_div_i  (baud_div_i),
        .rx_i        (rx_i),
        .data_o      (rx_data_o),
        .valid_o     (rx_valid_o),
        .frame_err_o (rx_frame_err_o)
    );

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
// uart receiver with line synchronizer, mid-bit sampling and stop-bit framing check
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                                  clk_i,
    input  wire                                  rst_i,
    input  wire  [uart_cfg_pkg::BAUD_W-1:0]      baud_div_i,
    input  wire                                  rx_i,
    output logic [uart_frame_pkg::DATA_BITS-1:0] data_o,
    output logic                                 valid_o,
    output logic                                 frame_err_o
);

    uart_frame_pkg::rx_state_e state_r;

    logic [uart_cfg_pkg::SYNC_STAGES-1:0]         sync_r;
    logic                                         rx_s;
    logic                                         rx_prev_r;
    logic                                         fall_edge;
    logic [uart_cfg_pkg::BAUD_W-1:0]              cnt_r;
    logic [uart_cfg_pkg::BAUD_W:0]                half_period;
    logic                                         half_tick;
    logic                                         baud_tick;
    logic [$clog2(uart_frame_pkg::DATA_BITS)-1:0] bit_idx_r;
    logic [uart_frame_pkg::DATA_BITS-1:0]         shift_r;
    logic                                         data_sample;

    assign rx_s      = sync_r[uart_cfg_pkg::SYNC_STAGES-1];
    assign fall_edge = rx_prev_r && !rx_s;

    // half a bit period, one bit wider so a full-scale divisor does not wrap
    assign half_period = ({1'b0, baud_div_i} + 1'b1) >> 1;
    assign half_tick   = {1'b0, cnt_r} >= half_period;
    assign baud_tick   = cnt_r == baud_div_i;

    assign data_sample = (state_r == uart_frame_pkg::RX_DATA) && baud_tick;

    assign data_o = shift_r; // stable while valid_o pulses since the FSM is back in idle

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync_r    <= '1; // idle line level, so reset does not look like a start bit
            rx_prev_r <= 1'b1;
        end else begin
            sync_r    <= {sync_r[uart_cfg_pkg::SYNC_STAGES-2:0], rx_i};
            rx_prev_r <= rx_s;
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_sample) begin
            shift_r <= {rx_s, shift_r[uart_frame_pkg::DATA_BITS-1:1]}; // LSB arrives first
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r     <= uart_frame_pkg::RX_IDLE;
            cnt_r       <= '0;
            bit_idx_r   <= '0;
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
            case (state_r)
                uart_frame_pkg::RX_IDLE: begin
                    if (fall_edge) begin
                        state_r <= uart_frame_pkg::RX_START;
                        cnt_r   <= 1; // the edge cycle counts toward the half period
                    end
                end
                uart_frame_pkg::RX_START: begin
                    if (half_tick) begin
                        cnt_r     <= '0;
                        bit_idx_r <= '0;
                        // a line back high at mid start bit was a glitch
                        state_r <= rx_s ? uart_frame_pkg::RX_IDLE : uart_frame_pkg::RX_DATA;
                    end else begin
                        cnt_r <= cnt_r + 1'b1;
                    end
                end
                uart_frame_pkg::RX_DATA: begin
                    if (baud_tick) begin
                        cnt_r <= '0;
                        if (int'(bit_idx_r) == uart_frame_pkg::DATA_BITS - 1) begin
                            state_r <= uart_frame_pkg::RX_STOP;
                        end else begin
                            bit_idx_r <= bit_idx_r + 1'b1;
                        end
                    end else begin
                        cnt_r <= cnt_r + 1'b1;
                    end
                end
                uart_frame_pkg::RX_STOP: begin
                    if (baud_tick) begin
                        cnt_r       <= '0;
                        state_r     <= uart_frame_pkg::RX_IDLE;
                        valid_o     <= rx_s;
                        frame_err_o <= !rx_s; // stop bit read low
                    end else begin
                        cnt_r <= cnt_r + 1'b1;
                    end
                end
                default: begin
                    state_r <= uart_frame_pkg::RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
// uart transmitter FSM sending 8N1 frames with a baud period set at run time
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                                  clk_i,
    input  wire                                  rst_i,
    input  wire  [uart_cfg_pkg::BAUD_W-1:0]      baud_div_i,
    input  wire                                  start_i,
    input  wire  [uart_frame_pkg::DATA_BITS-1:0] data_i,
    output logic                                 ready_o,
    output logic                                 tx_o
);

    uart_frame_pkg::tx_state_e state_r;
    uart_frame_pkg::tx_state_e state_nxt;

    logic [uart_cfg_pkg::BAUD_W-1:0]              baud_cnt_r;
    logic [uart_cfg_pkg::BAUD_W-1:0]              baud_cnt_nxt;
    logic [$clog2(uart_frame_pkg::DATA_BITS)-1:0] bit_idx_r;
    logic [$clog2(uart_frame_pkg::DATA_BITS)-1:0] bit_idx_nxt;
    logic [uart_frame_pkg::DATA_BITS-1:0]         data_r;
    logic                                         baud_tick;

    assign baud_tick = baud_cnt_r == baud_div_i; // last cycle of the current bit

    // ready means the FSM heads for idle unless a new frame starts now
    // it is built without start_i so the core can form start from it
    assign ready_o = (state_r == uart_frame_pkg::TX_IDLE) ||
                     (state_r == uart_frame_pkg::TX_STOP && baud_tick);

    always_comb begin
        state_nxt    = state_r;
        baud_cnt_nxt = baud_cnt_r;
        bit_idx_nxt  = bit_idx_r;
        tx_o         = 1'b1;
        case (state_r)
            uart_frame_pkg::TX_IDLE: begin
                if (start_i) begin
                    state_nxt    = uart_frame_pkg::TX_START;
                    baud_cnt_nxt = '0;
                end
            end
            uart_frame_pkg::TX_START: begin
                tx_o = 1'b0;
                if (baud_tick) begin
                    state_nxt    = uart_frame_pkg::TX_DATA;
                    baud_cnt_nxt = '0;
                end else begin
                    baud_cnt_nxt = baud_cnt_r + 1'b1;
                end
            end
            uart_frame_pkg::TX_DATA: begin
                tx_o = data_r[bit_idx_r];
                if (baud_tick) begin
                    baud_cnt_nxt = '0;
                    if (int'(bit_idx_r) == uart_frame_pkg::DATA_BITS - 1) begin
                        state_nxt   = uart_frame_pkg::TX_STOP;
                        bit_idx_nxt = '0;
                    end else begin
                        bit_idx_nxt = bit_idx_r + 1'b1;
                    end
                end else begin
                    baud_cnt_nxt = baud_cnt_r + 1'b1;
                end
            end
            uart_frame_pkg::TX_STOP: begin
                if (baud_tick) begin
                    baud_cnt_nxt = '0;
                    // a waiting byte goes straight into its start bit
                    state_nxt = start_i ? uart_frame_pkg::TX_START : uart_frame_pkg::TX_IDLE;
                end else begin
                    baud_cnt_nxt = baud_cnt_r + 1'b1;
                end
            end
            default: begin
                state_nxt = uart_frame_pkg::TX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (start_i && ready_o) begin
            data_r <= data_i; // held for the whole frame so the FIFO can move on
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_r    <= uart_frame_pkg::TX_IDLE;
            baud_cnt_r <= '0;
            bit_idx_r  <= '0;
        end else begin
            state_r    <= state_nxt;
            baud_cnt_r <= baud_cnt_nxt;
            bit_idx_r  <= bit_idx_nxt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx_fifo.sv
// transmit FIFO holding bytes between the write port and the serializer
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo (
    input  wire                                  clk_i,
    input  wire                                  rst_i,
    input  wire                                  push_i,
    input  wire  [uart_frame_pkg::DATA_BITS-1:0] push_data_i,
    input  wire                                  pop_i,
    output logic [uart_frame_pkg::DATA_BITS-1:0] pop_data_o,
    output logic                                 empty_o,
    output logic                                 full_o
);

    logic [uart_frame_pkg::DATA_BITS-1:0] mem [uart_cfg_pkg::FIFO_DEPTH];
    logic [uart_cfg_pkg::FIFO_ADDR_W-1:0] wr_ptr_r;
    logic [uart_cfg_pkg::FIFO_ADDR_W-1:0] rd_ptr_r;
    logic [uart_cfg_pkg::FIFO_ADDR_W:0]   count_r; // one bit wider to hold a full count
    logic                                 push_ok;
    logic                                 pop_ok;

    assign empty_o = count_r == '0;
    assign full_o  = count_r == (uart_cfg_pkg::FIFO_ADDR_W + 1)'(uart_cfg_pkg::FIFO_DEPTH);

    assign push_ok = push_i && !full_o;  // a push into a full FIFO is dropped
    assign pop_ok  = pop_i && !empty_o;

    assign pop_data_o = mem[rd_ptr_r]; // oldest entry is always on the output

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem[wr_ptr_r] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r; // both or neither leaves the count alone
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_cfg_pkg.sv
// sizing constants for the baud divisor, the transmit FIFO and the receive synchronizer
`default_nettype none

package uart_cfg_pkg;

    // a bit lasts divisor + 1 clock cycles
    localparam int BAUD_W = 16;

    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_ADDR_W = 3; // pointers wrap at FIFO_DEPTH

    // flops between the rx pin and the receiver FSM
    localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

// File: verilog/uart_frame_pkg.sv
// uart frame format and the state encodings of the transmitter and receiver FSMs
`default_nettype none

package uart_frame_pkg;

    // one start bit, DATA_BITS data bits sent LSB first, one stop bit, no parity
    localparam int DATA_BITS = 8;

    typedef enum logic [1:0] {
        TX_IDLE,  // line held high, waiting for a byte
        TX_START, // start bit, line low
        TX_DATA,  // data bits, LSB first
        TX_STOP   // stop bit, line high
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,  // waiting for a falling edge on the synchronized line
        RX_START, // counting half a bit to the middle of the start bit
        RX_DATA,  // sampling data bits at whole bit periods
        RX_STOP   // sampling the stop bit
    } rx_state_e;

endpackage

`default_nettype wire
